//--- nlb_defines.svh
`ifndef NLB_DEFINES_SVH
`define NLB_DEFINES_SVH

// Line address, line data and counter widths
`define NLB_ADDR_W  20
`define NLB_LINE_W  64
`define NLB_CNT_W   32
`define NLB_MODE_W  3

// Register port
`define NLB_MMIO_AW 16
`define NLB_MMIO_DW 64

// Register byte offsets
`define NLB_OFF_SCRATCH 16'h0100
`define NLB_OFF_SRC     16'h0120
`define NLB_OFF_DST     16'h0128
`define NLB_OFF_NLINES  16'h0130
`define NLB_OFF_CTL     16'h0138
`define NLB_OFF_CFG     16'h0140
`define NLB_OFF_STATUS  16'h0160
`define NLB_OFF_NREADS  16'h0168
`define NLB_OFF_NWRITES 16'h0170

`endif

//--- nlb_pkg.sv
`default_nettype none
`include "nlb_defines.svh"

package nlb_pkg;

   // ------------------------------
   // Test modes
   // ------------------------------
   // Codes 3 to 7 run as WRITE
   typedef enum logic [`NLB_MODE_W-1:0]
   {
      LPBK1 = 3'd0,
      READ  = 3'd1,
      WRITE = 3'd2
   } test_mode_e;

   // Per-line sequencing
   typedef enum logic [2:0]
   {
      IDLE,
      RD_OP,
      WR_OP,
      ADVANCE,
      DONE
   } fsm_state_e;

   // ------------------------------
   // Register word layouts
   // ------------------------------
   // CTL, bit 0 is the active low test reset
   typedef struct packed
   {
      logic [`NLB_MMIO_DW-4:0] rsvd;
      logic                    force_cmp;
      logic                    start;
      logic                    reset_n;
   } ctl_view_s;

   // CFG, only the mode field at 4:2 survives
   typedef struct packed
   {
      logic [`NLB_MMIO_DW-6:0] rsvd_hi;
      logic [`NLB_MODE_W-1:0]  mode;
      logic [1:0]              rsvd_lo;
   } cfg_view_s;

   // One register word, read by offset as control or as config
   typedef union packed
   {
      logic [`NLB_MMIO_DW-1:0] raw;
      ctl_view_s               ctl;
      cfg_view_s               cfg;
   } csr_wdata_u;

endpackage

`default_nettype wire

//--- nlb_csr.sv
`default_nettype none
`include "nlb_defines.svh"

module nlb_csr
(
   input  wire                      Clk_400,
   input  wire                      arst_n,
   // Register port
   input  wire                      mmio_req,
   input  wire                      mmio_we,
   input  wire [`NLB_MMIO_AW-1:0]   mmio_addr,
   input  wire [`NLB_MMIO_DW-1:0]   mmio_wdata,
   output logic                     mmio_ack,
   output logic [`NLB_MMIO_DW-1:0]  mmio_rdata,
   // Test status
   input  wire                      running,
   input  wire                      done,
   input  wire [`NLB_CNT_W-1:0]     num_reads,
   input  wire [`NLB_CNT_W-1:0]     num_writes,
   // Test setup
   output logic                     test_rst_n,
   output logic                     start,
   output logic                     force_cmp,
   output nlb_pkg::test_mode_e      mode,
   output logic [`NLB_ADDR_W-1:0]   src_base,
   output logic [`NLB_ADDR_W-1:0]   dst_base,
   output logic [`NLB_CNT_W-1:0]    num_lines
);

   logic                      req_q;
   logic                      access;
   logic                      wr_stb;
   logic [`NLB_MODE_W-1:0]    mode_q;
   logic [`NLB_MMIO_DW-1:0]   scratch_q;
   nlb_pkg::csr_wdata_u       wword;
   nlb_pkg::csr_wdata_u       rword;

   // ------------------------------
   // Four-phase handshake
   // ------------------------------
   // Req is sampled once, ack trails the sample by one edge
   always_ff @(posedge Clk_400 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         req_q    <= 1'b0;
         mmio_ack <= 1'b0;
      end
      else
      begin
         req_q    <= mmio_req;
         mmio_ack <= req_q;
      end
   end

   // Exactly one access per request, on the edge that raises ack
   assign access    = req_q && !mmio_ack;
   assign wr_stb    = access && mmio_we;
   assign wword.raw = mmio_wdata;

   // ------------------------------
   // Register file
   // ------------------------------
   always_ff @(posedge Clk_400 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         scratch_q  <= '0;
         test_rst_n <= 1'b0;
         start      <= 1'b0;
         force_cmp  <= 1'b0;
         src_base   <= '0;
         dst_base   <= '0;
         num_lines  <= '0;
         mode_q     <= '0;
      end
      else
      begin
         // Scratchpad and CTL live through test reset
         if (wr_stb && mmio_addr == `NLB_OFF_SCRATCH)
            scratch_q <= wword.raw;
         if (wr_stb && mmio_addr == `NLB_OFF_CTL)
         begin
            test_rst_n <= wword.ctl.reset_n;
            start      <= wword.ctl.start;
            force_cmp  <= wword.ctl.force_cmp;
         end
         // Test setup, cleared by test reset and locked during a run
         if (!test_rst_n)
         begin
            src_base  <= '0;
            dst_base  <= '0;
            num_lines <= '0;
            mode_q    <= '0;
         end
         else if (wr_stb && !running)
         begin
            case (mmio_addr)
               `NLB_OFF_SRC:    src_base  <= wword.raw[`NLB_ADDR_W-1:0];
               `NLB_OFF_DST:    dst_base  <= wword.raw[`NLB_ADDR_W-1:0];
               `NLB_OFF_NLINES: num_lines <= wword.raw[`NLB_CNT_W-1:0];
               `NLB_OFF_CFG:    mode_q    <= wword.cfg.mode;
               default:         ;
            endcase
         end
      end
   end

   // Unlisted codes pass through, the FSM runs them as WRITE
   assign mode = nlb_pkg::test_mode_e'(mode_q);

   // ------------------------------
   // Read back
   // ------------------------------
   always_comb
   begin
      rword.raw = '0;
      case (mmio_addr)
         `NLB_OFF_SCRATCH: rword.raw = scratch_q;
         `NLB_OFF_SRC:     rword.raw[`NLB_ADDR_W-1:0] = src_base;
         `NLB_OFF_DST:     rword.raw[`NLB_ADDR_W-1:0] = dst_base;
         `NLB_OFF_NLINES:  rword.raw[`NLB_CNT_W-1:0] = num_lines;
         `NLB_OFF_CTL:
         begin
            rword.ctl.reset_n   = test_rst_n;
            rword.ctl.start     = start;
            rword.ctl.force_cmp = force_cmp;
         end
         `NLB_OFF_CFG:     rword.cfg.mode = mode_q;
         // completion flag only
         `NLB_OFF_STATUS:  rword.raw[0] = done;
         `NLB_OFF_NREADS:  rword.raw[`NLB_CNT_W-1:0] = num_reads;
         `NLB_OFF_NWRITES: rword.raw[`NLB_CNT_W-1:0] = num_writes;
         default:          rword.raw = '0;
      endcase
   end

   // Held for the whole ack high phase
   always_ff @(posedge Clk_400)
   begin
      if (access && !mmio_we)
         mmio_rdata <= rword.raw;
   end

   // Ack rises only for a request the host is still holding
   ack_needs_req: assert property (@(posedge Clk_400) disable iff (!arst_n)
      $rose(mmio_ack) |-> $past(mmio_req));

endmodule

`default_nettype wire

//--- nlb_test_fsm.sv
`default_nettype none

module nlb_test_fsm
(
   input  wire                      Clk_400,
   input  wire                      arst_n,
   // From the register file
   input  wire                      test_rst_n,
   input  wire                      start,
   input  wire                      force_cmp,
   input  wire nlb_pkg::test_mode_e mode,
   // Memory op and line status
   input  wire                      op_done,
   input  wire                      last_line,
   output logic                     rd_go,
   output logic                     wr_go,
   output logic                     lpbk,
   // Counter control
   output logic                     clear,
   output logic                     line_adv,
   output logic                     cnt_rd,
   output logic                     cnt_wr,
   // Test status
   output logic                     running,
   output logic                     done
);

   nlb_pkg::fsm_state_e state;
   nlb_pkg::fsm_state_e state_nxt;
   logic                rd_first;
   logic                start_ok;
   logic                launch;
   logic                line_end;

   // ------------------------------
   // Mode decode
   // ------------------------------
   always_comb
   begin
      case (mode)
         nlb_pkg::LPBK1:
         begin
            lpbk     = 1'b1;
            rd_first = 1'b1;
         end
         nlb_pkg::READ:
         begin
            lpbk     = 1'b0;
            rd_first = 1'b1;
         end
         // WRITE and every unused code
         default:
         begin
            lpbk     = 1'b0;
            rd_first = 1'b0;
         end
      endcase
   end

   // ------------------------------
   // Pulses
   // ------------------------------
   assign start_ok = test_rst_n && start && state == nlb_pkg::IDLE;
   // First op of each line with line_idx already pointing at it
   assign launch   = start_ok || (test_rst_n && state == nlb_pkg::ADVANCE);
   assign cnt_rd   = state == nlb_pkg::RD_OP && op_done;
   assign cnt_wr   = state == nlb_pkg::WR_OP && op_done;
   assign rd_go    = launch && rd_first;
   // Loopback chains its write straight after the read
   assign wr_go    = (launch && !rd_first) || (cnt_rd && lpbk && !force_cmp);
   assign line_end = cnt_wr || (cnt_rd && !lpbk);
   assign line_adv = line_end && !last_line && !force_cmp;
   assign clear    = !test_rst_n || start_ok;

   // ------------------------------
   // State
   // ------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         nlb_pkg::IDLE:
            if (start_ok)
               state_nxt = rd_first ? nlb_pkg::RD_OP : nlb_pkg::WR_OP;
         nlb_pkg::RD_OP:
            if (op_done)
            begin
               if (wr_go)
                  state_nxt = nlb_pkg::WR_OP;
               else
                  state_nxt = line_adv ? nlb_pkg::ADVANCE : nlb_pkg::DONE;
            end
         nlb_pkg::WR_OP:
            if (op_done)
               state_nxt = line_adv ? nlb_pkg::ADVANCE : nlb_pkg::DONE;
         nlb_pkg::ADVANCE:
            state_nxt = rd_first ? nlb_pkg::RD_OP : nlb_pkg::WR_OP;
         // DONE waits for test reset
         default:
            state_nxt = state;
      endcase
   end

   always_ff @(posedge Clk_400 or negedge arst_n)
   begin
      if (!arst_n)
         state <= nlb_pkg::IDLE;
      else if (!test_rst_n)
         state <= nlb_pkg::IDLE;
      else
         state <= state_nxt;
   end

   assign running = state != nlb_pkg::IDLE && state != nlb_pkg::DONE;
   assign done    = state == nlb_pkg::DONE;

   state_legal: assert property (@(posedge Clk_400) disable iff (!arst_n)
      state inside {nlb_pkg::IDLE, nlb_pkg::RD_OP, nlb_pkg::WR_OP,
                    nlb_pkg::ADVANCE, nlb_pkg::DONE});

endmodule

`default_nettype wire

//--- nlb_line_counter.sv
`default_nettype none
`include "nlb_defines.svh"

module nlb_line_counter
(
   input  wire                    Clk_400,
   input  wire                    arst_n,
   input  wire                    clear,
   input  wire                    line_adv,
   input  wire                    cnt_rd,
   input  wire                    cnt_wr,
   input  wire [`NLB_CNT_W-1:0]   num_lines,
   output logic [`NLB_CNT_W-1:0]  line_idx,
   output logic                   last_line,
   output logic [`NLB_CNT_W-1:0]  num_reads,
   output logic [`NLB_CNT_W-1:0]  num_writes
);

   localparam logic [`NLB_CNT_W-1:0] cnt_one = {{(`NLB_CNT_W-1){1'b0}}, 1'b1};

   logic [`NLB_CNT_W-1:0] lines_eff;
   logic [`NLB_CNT_W-1:0] idx_nxt;

   // A zero count still runs one line
   assign lines_eff = (num_lines == '0) ? cnt_one : num_lines;
   assign idx_nxt   = line_idx + cnt_one;
   assign last_line = idx_nxt == lines_eff;

   // Line index and completed traffic
   always_ff @(posedge Clk_400 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         line_idx   <= '0;
         num_reads  <= '0;
         num_writes <= '0;
      end
      else if (clear)
      begin
         line_idx   <= '0;
         num_reads  <= '0;
         num_writes <= '0;
      end
      else
      begin
         if (line_adv)
            line_idx <= idx_nxt;
         if (cnt_rd)
            num_reads <= num_reads + cnt_one;
         if (cnt_wr)
            num_writes <= num_writes + cnt_one;
      end
   end

endmodule

`default_nettype wire

//--- nlb_mem_port.sv
`default_nettype none
`include "nlb_defines.svh"

module nlb_mem_port
(
   input  wire                     Clk_400,
   input  wire                     arst_n,
   // From the FSM
   input  wire                     rd_go,
   input  wire                     wr_go,
   input  wire                     lpbk,
   output logic                    op_done,
   // Addressing
   input  wire [`NLB_ADDR_W-1:0]   src_base,
   input  wire [`NLB_ADDR_W-1:0]   dst_base,
   input  wire [`NLB_CNT_W-1:0]    line_idx,
   // Memory port
   output logic                    mem_req,
   output logic                    mem_we,
   output logic [`NLB_ADDR_W-1:0]  mem_addr,
   output logic [`NLB_LINE_W-1:0]  mem_wdata,
   input  wire                     mem_ack,
   input  wire [`NLB_LINE_W-1:0]   mem_rdata
);

   logic                   wait_low;
   logic [`NLB_ADDR_W-1:0] line_off;
   logic [`NLB_LINE_W-1:0] idx_data;
   logic [`NLB_LINE_W-1:0] rd_line;

   // Buffers are line addressed, the offset is just the index
   assign line_off = line_idx[`NLB_ADDR_W-1:0];
   // WRITE mode pattern
   assign idx_data = {{(`NLB_LINE_W-`NLB_CNT_W){1'b0}}, line_idx};

   // ------------------------------
   // Request handshake
   // ------------------------------
   // req up on go, down on ack, op_done once ack is seen low
   always_ff @(posedge Clk_400 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mem_req  <= 1'b0;
         mem_we   <= 1'b0;
         wait_low <= 1'b0;
         op_done  <= 1'b0;
      end
      else
      begin
         op_done <= 1'b0;
         if (rd_go || wr_go)
         begin
            mem_req <= 1'b1;
            mem_we  <= wr_go;
         end
         else if (mem_req && mem_ack)
         begin
            mem_req  <= 1'b0;
            wait_low <= 1'b1;
         end
         else if (wait_low && !mem_ack)
         begin
            wait_low <= 1'b0;
            op_done  <= 1'b1;
         end
      end
   end

   // ------------------------------
   // Address and data
   // ------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rd_go || wr_go)
      begin
         mem_addr  <= wr_go ? dst_base + line_off : src_base + line_off;
         mem_wdata <= lpbk ? rd_line : idx_data;
      end
      // Loopback line, kept until its write is issued
      if (mem_req && mem_ack && !mem_we)
         rd_line <= mem_rdata;
   end

   req_stable: assert property (@(posedge Clk_400) disable iff (!arst_n)
      mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_wdata));

   // The FSM waits for op_done, so no go while an op is open
   go_when_idle: assert property (@(posedge Clk_400) disable iff (!arst_n)
      (rd_go || wr_go) |-> !mem_req && !wait_low);

endmodule

`default_nettype wire

//--- nlb_top.sv
`default_nettype none
`include "nlb_defines.svh"

module nlb_top
(
   input  wire                     Clk_400,
   input  wire                     arst_n,
   // Register port
   input  wire                     mmio_req,
   input  wire                     mmio_we,
   input  wire [`NLB_MMIO_AW-1:0]  mmio_addr,
   input  wire [`NLB_MMIO_DW-1:0]  mmio_wdata,
   output wire                     mmio_ack,
   output wire [`NLB_MMIO_DW-1:0]  mmio_rdata,
   // Memory port
   output wire                     mem_req,
   output wire                     mem_we,
   output wire [`NLB_ADDR_W-1:0]   mem_addr,
   output wire [`NLB_LINE_W-1:0]   mem_wdata,
   input  wire                     mem_ack,
   input  wire [`NLB_LINE_W-1:0]   mem_rdata
);

   // ------------------------------
   // Setup and status
   // ------------------------------
   wire                      test_rst_n;
   wire                      start;
   wire                      force_cmp;
   wire nlb_pkg::test_mode_e mode;
   wire [`NLB_ADDR_W-1:0]    src_base;
   wire [`NLB_ADDR_W-1:0]    dst_base;
   wire [`NLB_CNT_W-1:0]     num_lines;
   wire [`NLB_CNT_W-1:0]     num_reads;
   wire [`NLB_CNT_W-1:0]     num_writes;
   wire                      running;
   wire                      done;

   // FSM pulses and line state
   wire                      rd_go;
   wire                      wr_go;
   wire                      lpbk;
   wire                      op_done;
   wire                      clear;
   wire                      line_adv;
   wire                      cnt_rd;
   wire                      cnt_wr;
   wire                      last_line;
   wire [`NLB_CNT_W-1:0]     line_idx;

   nlb_csr u_csr
   (
      .Clk_400, .arst_n,
      .mmio_req, .mmio_we, .mmio_addr, .mmio_wdata, .mmio_ack, .mmio_rdata,
      .running, .done, .num_reads, .num_writes,
      .test_rst_n, .start, .force_cmp, .mode,
      .src_base, .dst_base, .num_lines
   );

   nlb_test_fsm u_fsm
   (
      .Clk_400, .arst_n,
      .test_rst_n, .start, .force_cmp, .mode,
      .op_done, .last_line, .rd_go, .wr_go, .lpbk,
      .clear, .line_adv, .cnt_rd, .cnt_wr,
      .running, .done
   );

   nlb_line_counter u_counter
   (
      .Clk_400, .arst_n,
      .clear, .line_adv, .cnt_rd, .cnt_wr, .num_lines,
      .line_idx, .last_line, .num_reads, .num_writes
   );

   nlb_mem_port u_mem_port
   (
      .Clk_400, .arst_n,
      .rd_go, .wr_go, .lpbk, .op_done,
      .src_base, .dst_base, .line_idx,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
   );

endmodule

`default_nettype wire

//--- tb_nlb_checks.svh
`ifndef TB_NLB_CHECKS_SVH
`define TB_NLB_CHECKS_SVH

   // ------------------------------
   // Failure handling
   // ------------------------------
   // Any failure ends the run on the spot
   task automatic fail_now(input string line);
      $display("%s", line);
      error_count++;
      finish_run();
   endtask

   // Whole register word, reserved bits included
   task automatic check_csr_word(input string name, input nlb_pkg::csr_wdata_u got,
                                 input nlb_pkg::csr_wdata_u exp);
      if (got.raw !== exp.raw)
         fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                            name, got.raw, exp.raw));
   endtask

   // One memory line as the model saw it
   task automatic check_mem_line(input string name, input logic [`NLB_LINE_W-1:0] got,
                                 input logic [`NLB_LINE_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Line address of a memory request
   task automatic check_mem_addr(input string name, input logic [`NLB_ADDR_W-1:0] got,
                                 input logic [`NLB_ADDR_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Traffic counters and request counts
   task automatic check_count(input string name, input logic [`NLB_CNT_W-1:0] got,
                              input logic [`NLB_CNT_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

`endif

//--- tb_nlb.sv
`default_nettype none
`include "nlb_defines.svh"

module tb_nlb;

   // Eight hex words per case in the vector file
   localparam int VEC_WORDS    = 8;
   localparam int MAX_VECS     = 16;
   // Watchdog budget in clock cycles
   localparam int CYC_PER_LINE = 40;
   localparam int CYC_PER_CASE = 600;
   localparam int CYC_MARGIN   = 2000;

   logic                     Clk_400;
   logic                     arst_n;
   logic                     mmio_req;
   logic                     mmio_we;
   logic [`NLB_MMIO_AW-1:0]  mmio_addr;
   logic [`NLB_MMIO_DW-1:0]  mmio_wdata;
   wire                      mmio_ack;
   wire  [`NLB_MMIO_DW-1:0]  mmio_rdata;
   wire                      mem_req;
   wire                      mem_we;
   wire  [`NLB_ADDR_W-1:0]   mem_addr;
   wire  [`NLB_LINE_W-1:0]   mem_wdata;
   logic                     mem_ack;
   logic [`NLB_LINE_W-1:0]   mem_rdata;

   // Memory contents and the traffic of the current case
   logic [`NLB_LINE_W-1:0]   mem_lines [logic [`NLB_ADDR_W-1:0]];
   logic [`NLB_ADDR_W-1:0]   rd_addr_q [$];
   logic [`NLB_ADDR_W-1:0]   wr_addr_q [$];
   logic [`NLB_LINE_W-1:0]   wr_data_q [$];
   logic [`NLB_LINE_W-1:0]   src_lines [$];
   logic [31:0]              delay_state;
   logic [31:0]              data_state;
   logic [`NLB_MMIO_DW-1:0]  scratch_val;

   // All ones past the last case
   logic [31:0]              vec_words [0:VEC_WORDS*MAX_VECS-1];
   int                       num_vecs;
   logic                     vecs_ready;
   int                       error_count;

   nlb_top u_dut
   (
      .Clk_400    (Clk_400),
      .arst_n     (arst_n),
      .mmio_req   (mmio_req),
      .mmio_we    (mmio_we),
      .mmio_addr  (mmio_addr),
      .mmio_wdata (mmio_wdata),
      .mmio_ack   (mmio_ack),
      .mmio_rdata (mmio_rdata),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata)
   );

   always #10 Clk_400 = ~Clk_400;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Lines never written keep a pattern built from the whole address
   function automatic logic [`NLB_LINE_W-1:0] read_line(input logic [`NLB_ADDR_W-1:0] addr);
      if (mem_lines.exists(addr))
         return mem_lines[addr];
      return {24'h5ac3e1, addr, addr};
   endfunction

   task automatic finish_run();
      if (error_count == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         $display("Errors found");
         $fatal(1, "simulation stopped at the first failure");
      end
   endtask

   `include "tb_nlb_checks.svh"

   // ------------------------------
   // Register port
   // ------------------------------
   task automatic mmio_access(input logic we, input logic [`NLB_MMIO_AW-1:0] addr,
                              input logic [`NLB_MMIO_DW-1:0] wdata,
                              output nlb_pkg::csr_wdata_u rdata);
      @(negedge Clk_400);
      mmio_req   = 1'b1;
      mmio_we    = we;
      mmio_addr  = addr;
      mmio_wdata = wdata;
      while (mmio_ack !== 1'b1)
         @(negedge Clk_400);
      // rdata is held while ack is high
      rdata.raw = mmio_rdata;
      mmio_req  = 1'b0;
      while (mmio_ack !== 1'b0)
         @(negedge Clk_400);
   endtask

   task automatic mmio_write(input logic [`NLB_MMIO_AW-1:0] addr,
                             input logic [`NLB_MMIO_DW-1:0] data);
      nlb_pkg::csr_wdata_u ignored;
      mmio_access(1'b1, addr, data, ignored);
   endtask

   task automatic mmio_read(input logic [`NLB_MMIO_AW-1:0] addr,
                            output nlb_pkg::csr_wdata_u word);
      mmio_access(1'b0, addr, '0, word);
   endtask

   task automatic expect_reg(input logic [`NLB_MMIO_AW-1:0] addr, input string name,
                             input logic [`NLB_MMIO_DW-1:0] value);
      nlb_pkg::csr_wdata_u got;
      nlb_pkg::csr_wdata_u exp;
      exp.raw = value;
      mmio_read(addr, got);
      check_csr_word(name, got, exp);
   endtask

   // Test reset drops the setup and the results, scratchpad stays
   task automatic check_test_reset();
      mmio_write(`NLB_OFF_CTL, '0);
      expect_reg(`NLB_OFF_STATUS, "STATUS after test reset", '0);
      expect_reg(`NLB_OFF_NREADS, "NREADS after test reset", '0);
      expect_reg(`NLB_OFF_NWRITES, "NWRITES after test reset", '0);
      expect_reg(`NLB_OFF_SRC, "SRC after test reset", '0);
      expect_reg(`NLB_OFF_DST, "DST after test reset", '0);
      expect_reg(`NLB_OFF_NLINES, "NLINES after test reset", '0);
      expect_reg(`NLB_OFF_CFG, "CFG after test reset", '0);
      expect_reg(`NLB_OFF_SCRATCH, "SCRATCH after test reset", scratch_val);
   endtask

   // ------------------------------
   // One vector
   // ------------------------------
   task automatic run_case(input int n);
      logic [2:0]               mode_bits;
      logic                     lpbk_mode;
      logic [`NLB_ADDR_W-1:0]   src;
      logic [`NLB_ADDR_W-1:0]   dst;
      logic [`NLB_ADDR_W-1:0]   addr;
      logic [`NLB_CNT_W-1:0]    nlines;
      logic [`NLB_CNT_W-1:0]    lines_eff;
      logic [`NLB_CNT_W-1:0]    force_at;
      logic [`NLB_CNT_W-1:0]    exp_done;
      logic [`NLB_CNT_W-1:0]    exp_reads;
      logic [`NLB_CNT_W-1:0]    exp_writes;
      logic [`NLB_CNT_W-1:0]    i;
      logic [`NLB_LINE_W-1:0]   line;
      nlb_pkg::csr_wdata_u      w;
      nlb_pkg::csr_wdata_u      r;
      mode_bits  = vec_words[n*VEC_WORDS][2:0];
      src        = vec_words[n*VEC_WORDS+1][`NLB_ADDR_W-1:0];
      dst        = vec_words[n*VEC_WORDS+2][`NLB_ADDR_W-1:0];
      nlines     = vec_words[n*VEC_WORDS+3];
      force_at   = vec_words[n*VEC_WORDS+4];
      exp_done   = vec_words[n*VEC_WORDS+5];
      exp_reads  = vec_words[n*VEC_WORDS+6];
      exp_writes = vec_words[n*VEC_WORDS+7];
      // Zero lines still runs one, only code 0 copies source data
      lines_eff  = (nlines == '0) ? 32'd1 : nlines;
      lpbk_mode  = mode_bits == 3'd0;
      // Leave test reset, then program the run
      w.raw = '0;
      w.ctl.reset_n = 1'b1;
      mmio_write(`NLB_OFF_CTL, w.raw);
      mmio_write(`NLB_OFF_SRC, {{(`NLB_MMIO_DW-`NLB_ADDR_W){1'b0}}, src});
      mmio_write(`NLB_OFF_DST, {{(`NLB_MMIO_DW-`NLB_ADDR_W){1'b0}}, dst});
      mmio_write(`NLB_OFF_NLINES, {{(`NLB_MMIO_DW-`NLB_CNT_W){1'b0}}, nlines});
      w.raw = '0;
      w.cfg.mode = mode_bits;
      mmio_write(`NLB_OFF_CFG, w.raw);
      rd_addr_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
      src_lines.delete();
      // Fresh random source lines
      for (i = 0; i < lines_eff; i++)
      begin
         addr       = src + i[`NLB_ADDR_W-1:0];
         data_state = xorshift32(data_state);
         line       = {data_state, data_state[11:0], addr};
         mem_lines[addr] = line;
         src_lines.push_back(line);
      end
      w.raw = '0;
      w.ctl.reset_n = 1'b1;
      w.ctl.start   = 1'b1;
      mmio_write(`NLB_OFF_CTL, w.raw);
      if (force_at != '0)
      begin
         while (wr_addr_q.size() < force_at)
            @(negedge Clk_400);
         // NLINES is locked while the test runs
         mmio_write(`NLB_OFF_NLINES, 64'h3);
         expect_reg(`NLB_OFF_NLINES, "NLINES during run",
                    {{(`NLB_MMIO_DW-`NLB_CNT_W){1'b0}}, nlines});
         w.ctl.force_cmp = 1'b1;
         mmio_write(`NLB_OFF_CTL, w.raw);
      end
      // Poll for completion
      do
         mmio_read(`NLB_OFF_STATUS, r);
      while (r.raw[0] !== 1'b1);
      w.raw = '0;
      w.raw[0] = exp_done[0];
      check_csr_word("STATUS", r, w);
      mmio_read(`NLB_OFF_NREADS, r);
      check_count("NREADS", r.raw[`NLB_CNT_W-1:0], exp_reads);
      check_count("read count", rd_addr_q.size(), exp_reads);
      mmio_read(`NLB_OFF_NWRITES, r);
      if (force_at != '0)
      begin
         check_count("NWRITES", r.raw[`NLB_CNT_W-1:0], wr_addr_q.size());
         if (wr_addr_q.size() >= exp_writes)
            fail_now("Force completion did not end the run before its last line");
      end
      else
      begin
         check_count("NWRITES", r.raw[`NLB_CNT_W-1:0], exp_writes);
         check_count("write count", wr_addr_q.size(), exp_writes);
      end
      // Lines go out in index order
      for (i = 0; i < rd_addr_q.size(); i++)
         check_mem_addr("read address", rd_addr_q[i], src + i[`NLB_ADDR_W-1:0]);
      for (i = 0; i < wr_addr_q.size(); i++)
      begin
         check_mem_addr("write address", wr_addr_q[i], dst + i[`NLB_ADDR_W-1:0]);
         line = lpbk_mode ? src_lines[i] : {{(`NLB_LINE_W-`NLB_CNT_W){1'b0}}, i};
         check_mem_line("write data", wr_data_q[i], line);
      end
      check_test_reset();
   endtask

   // ------------------------------
   // Memory model
   // ------------------------------
   // Answers each request after 0 to 3 cycles, inputs change on the falling edge
   initial
   begin : memory_model
      mem_ack     = 1'b0;
      mem_rdata   = '0;
      delay_state = 32'd58662;
      forever
      begin
         @(negedge Clk_400);
         if (mem_req === 1'b1)
         begin
            delay_state = xorshift32(delay_state);
            repeat (delay_state[1:0])
               @(negedge Clk_400);
            if (mem_we)
            begin
               wr_addr_q.push_back(mem_addr);
               wr_data_q.push_back(mem_wdata);
               mem_lines[mem_addr] = mem_wdata;
            end
            else
            begin
               rd_addr_q.push_back(mem_addr);
               mem_rdata = read_line(mem_addr);
            end
            mem_ack = 1'b1;
            while (mem_req === 1'b1)
               @(negedge Clk_400);
            mem_ack = 1'b0;
         end
      end
   end

   // Budget grows with the line count of every case
   initial
   begin : watchdog
      int          limit;
      logic [31:0] lines;
      wait (vecs_ready === 1'b1);
      limit = CYC_MARGIN;
      for (int n = 0; n < num_vecs; n++)
      begin
         lines = vec_words[n*VEC_WORDS+3];
         if (lines == '0)
            lines = 32'd1;
         limit = limit + CYC_PER_CASE + CYC_PER_LINE * int'(lines);
      end
      repeat (limit)
         @(posedge Clk_400);
      fail_now("Timeout: the DUT stopped answering and the test hung");
   end

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin : main_flow
      int n;
      Clk_400     = 1'b0;
      arst_n      = 1'b0;
      mmio_req    = 1'b0;
      mmio_we     = 1'b0;
      mmio_addr   = '0;
      mmio_wdata  = '0;
      error_count = 0;
      vecs_ready  = 1'b0;
      data_state  = 32'd58662;
      for (n = 0; n < VEC_WORDS*MAX_VECS; n++)
         vec_words[n] = '1;
      $readmemh("tb_nlb_vectors.txt", vec_words);
      num_vecs = 0;
      while (num_vecs < MAX_VECS && vec_words[num_vecs*VEC_WORDS] != '1)
         num_vecs++;
      vecs_ready = 1'b1;
      repeat (16)
         @(posedge Clk_400);
      @(negedge Clk_400);
      arst_n = 1'b1;
      if (num_vecs == 0)
         fail_now("No test cases were read from the vector file");
      // Idle after reset, then scratchpad and an unmapped offset
      expect_reg(`NLB_OFF_STATUS, "STATUS after reset", '0);
      scratch_val = {xorshift32(data_state), data_state};
      mmio_write(`NLB_OFF_SCRATCH, scratch_val);
      expect_reg(`NLB_OFF_SCRATCH, "SCRATCH", scratch_val);
      expect_reg(16'h0108, "unknown offset 0x0108", '0);
      expect_reg(16'h0200, "unknown offset 0x0200", '0);
      for (n = 0; n < num_vecs; n++)
         run_case(n);
      finish_run();
   end

endmodule

`default_nettype wire

//--- tb_nlb_vectors.txt
// mode src dst num_lines force_after exp_done exp_reads exp_writes, all hex
// mode 0 LPBK1, 1 READ, 2 WRITE; force_after counts model writes, 0 for no force
// On a forced row exp_writes is the count the cut-short run must stay below
// WRITE, eight lines
2 00100 00800 00000008 0 1 0 8
// READ, six lines
1 00200 00900 00000006 0 1 6 0
// LPBK1, sixteen lines
0 00300 00a00 00000010 0 1 10 10
// LPBK1, single line
0 00340 00a40 00000001 0 1 1 1
// Zero count runs one line
2 00400 00b00 00000000 0 1 0 1
1 00420 00b20 00000000 0 1 1 0
// Unused mode code runs as WRITE
5 00500 00c00 00000004 0 1 0 4
// Source wraps at the top of the line space
0 ffff8 01000 00000010 0 1 10 10
// Long WRITE, forced after 32 writes
2 02000 40000 00000200 20 1 0 200
// LPBK1, thirty-two lines
0 03000 05000 00000020 0 1 20 20
// READ, three lines
1 06000 07000 00000003 0 1 3 0

//--- tb.f
+incdir+.
nlb_pkg.sv
nlb_csr.sv
nlb_test_fsm.sv
nlb_line_counter.sv
nlb_mem_port.sv
nlb_top.sv
tb_nlb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the NLB testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_nlb_sim

echo "Building with Verilator"
verilator --binary --timing --assert -f tb.f --top-module tb_nlb -o "$BIN"
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

echo "Running simulation"
./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
